/* hdl/spim_pkg.sv */
// shared address map, register layout and buffer types, imported by every spi master module
package spim_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////
	localparam int DATA_W    = 32;
	localparam int BUF_DEPTH = 64;                 // words per buffer
	localparam int BUF_AW    = $clog2(BUF_DEPTH);  // ram address bits
	localparam int BUF_LVL_W = BUF_AW + 1;         // level spans 0..BUF_DEPTH

	// buffer windows in the host and spi address space
	localparam logic [15:0] WBUF_BASE = 16'h0200;
	localparam logic [15:0] WBUF_LAST = 16'h09FF;
	localparam logic [15:0] RBUF_BASE = 16'h1000;
	localparam logic [15:0] RBUF_LAST = 16'h17FF;

	typedef enum logic [15:0] {
		CSR_CMD       = 16'h0000,
		CSR_STATUS    = 16'h0004,
		CSR_DIAG0     = 16'h0008,
		CSR_DIAG1     = 16'h000C,
		CSR_BUF_CTRL  = 16'h0010,
		CSR_BUF_LEVEL = 16'h0014
	} csr_addr_e;

	typedef enum logic [1:0] {
		ACC_NONE = 2'd0,  // hole in the map
		ACC_CSR  = 2'd1,  // anything below WBUF_BASE
		ACC_WBUF = 2'd2,
		ACC_RBUF = 2'd3
	} acc_kind_e;

	// command register, msb first
	typedef struct packed {
		logic [1:0]  sselect;  // slave select
		logic [13:0] rsvd;
		logic [13:0] brstlen;  // burst length in words
		logic        rdnwr;
		logic        transvld; // transaction valid, cleared by the spi side
	} spim_cmd_t;

	typedef struct packed {
		logic [BUF_LVL_W-1:0] level;
		logic                 full;
		logic                 empty;
		logic                 overflow;  // sticky
		logic                 underflow; // sticky
	} buf_stat_t;

	// status register bits
	localparam int ST_WBUF_OVF = 0;
	localparam int ST_WBUF_UDF = 1;
	localparam int ST_RBUF_OVF = 2;
	localparam int ST_RBUF_UDF = 3;

	// buffer control bits, write one to pulse
	localparam int CTRL_WBUF_SRST = 0;
	localparam int CTRL_RBUF_SRST = 1;

endpackage

/* hdl/spim_buf_fifo.sv */
// single clock fwft word buffer with level and sticky error flags, used for both transfer directions
`timescale 1ns/10ps

module spim_buf_fifo
	import spim_pkg::*;
(
	input  logic              m_avmm_clk,
	input  logic              m_avmm_rst_n,
	input  logic              push,
	input  logic              pop,
	input  logic              srst,     // firmware soft reset, one cycle
	input  logic [DATA_W-1:0] wrdata,
	output logic [DATA_W-1:0] head,     // zero while empty
	output buf_stat_t         stat
);

	logic [DATA_W-1:0]    mem [BUF_DEPTH];
	logic [BUF_AW:0]      wr_ptr;       // extra msb tells full from empty
	logic [BUF_AW:0]      rd_ptr;
	logic [BUF_LVL_W-1:0] level;
	logic                 full;
	logic                 empty;
	logic                 do_push;
	logic                 do_pop;
	logic                 ovf_q;
	logic                 udf_q;

	assign level = wr_ptr - rd_ptr;
	assign full  = (level == BUF_LVL_W'(BUF_DEPTH));
	assign empty = (level == '0);

	assign do_push = push & ~full;  // a full push is dropped
	assign do_pop  = pop & ~empty;

	//////////////////////////////////////////////////
	// pointers and sticky flags
	//////////////////////////////////////////////////
	always_ff @(posedge m_avmm_clk or negedge m_avmm_rst_n) begin
		if (!m_avmm_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			ovf_q  <= 1'b0;
			udf_q  <= 1'b0;
		end else if (srst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			ovf_q  <= 1'b0;
			udf_q  <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push & full)
				ovf_q <= 1'b1;
			if (pop & empty)
				udf_q <= 1'b1;
		end
	end

	// storage
	always_ff @(posedge m_avmm_clk) begin
		if (do_push)
			mem[wr_ptr[BUF_AW-1:0]] <= wrdata;
	end

	assign head = empty ? '0 : mem[rd_ptr[BUF_AW-1:0]];

	always_comb begin
		stat.level     = level;
		stat.full      = full;
		stat.empty     = empty;
		stat.overflow  = ovf_q;
		stat.underflow = udf_q;
	end

	// pointer distance must stay inside the ram
	a_level_bound: assert property (@(posedge m_avmm_clk) disable iff (!m_avmm_rst_n)
		level <= BUF_LVL_W'(BUF_DEPTH));

	// full means only the pointer msbs differ, empty means equal pointers
	a_full_empty: assert property (@(posedge m_avmm_clk) disable iff (!m_avmm_rst_n)
		(full == ((wr_ptr ^ rd_ptr) == {1'b1, {BUF_AW{1'b0}}})) &&
		(empty == (wr_ptr == rd_ptr)) && !(full && empty));

endmodule

/* hdl/spim_csr.sv */
// command, status, diagnostic and buffer registers of the spi master, with the register read mux
`timescale 1ns/10ps

module spim_csr
	import spim_pkg::*;
(
	input  logic              m_avmm_clk,
	input  logic              m_avmm_rst_n,
	input  logic              csr_wr,        // accepted host write
	input  logic              csr_rd,        // accepted host read
	input  csr_addr_e         addr,
	input  logic [DATA_W-1:0] wdata,
	input  logic              stransvld_up,  // spi side done with the command
	input  logic              ssn_off_pulse,
	input  logic [DATA_W-1:0] dbg_bus0,
	input  logic [DATA_W-1:0] dbg_bus1,
	input  buf_stat_t         wbuf_stat,
	input  buf_stat_t         rbuf_stat,
	output logic [DATA_W-1:0] rdata,
	output logic              wbuf_srst,
	output logic              rbuf_srst,
	output spim_cmd_t         spim_cmd
);

	spim_cmd_t         cmd_q;
	logic [DATA_W-1:0] diag0_q;
	logic [DATA_W-1:0] diag1_q;
	logic [DATA_W-1:0] status_w;
	logic [DATA_W-1:0] level_w;
	logic              cmd_wr;
	logic              ctrl_wr;

	assign cmd_wr  = csr_wr & (addr == CSR_CMD);
	assign ctrl_wr = csr_wr & (addr == CSR_BUF_CTRL);

	//////////////////////////////////////////////////
	// command register
	//////////////////////////////////////////////////
	always_ff @(posedge m_avmm_clk or negedge m_avmm_rst_n) begin
		if (!m_avmm_rst_n)
			cmd_q <= '0;
		else if (cmd_wr)
			cmd_q <= spim_cmd_t'(wdata);  // host write beats the clear
		else if (stransvld_up)
			cmd_q.transvld <= 1'b0;
	end

	assign spim_cmd = cmd_q;

	// diag0 snapshot at slave deselect, diag1 free running
	always_ff @(posedge m_avmm_clk or negedge m_avmm_rst_n) begin
		if (!m_avmm_rst_n) begin
			diag0_q <= '0;
			diag1_q <= '0;
		end else begin
			if (ssn_off_pulse & ~stransvld_up)
				diag0_q <= dbg_bus0;
			diag1_q <= dbg_bus1;
		end
	end

	// soft reset pulses reach the buffers in the write cycle
	assign wbuf_srst = ctrl_wr & wdata[CTRL_WBUF_SRST];
	assign rbuf_srst = ctrl_wr & wdata[CTRL_RBUF_SRST];

	//////////////////////////////////////////////////
	// read path
	//////////////////////////////////////////////////
	always_comb begin
		status_w              = '0;
		status_w[ST_WBUF_OVF] = wbuf_stat.overflow;
		status_w[ST_WBUF_UDF] = wbuf_stat.underflow;
		status_w[ST_RBUF_OVF] = rbuf_stat.overflow;
		status_w[ST_RBUF_UDF] = rbuf_stat.underflow;
	end

	always_comb begin
		level_w                        = '0;
		level_w[BUF_LVL_W-1:0]         = wbuf_stat.level;  // bits 6:0
		level_w[16 +: BUF_LVL_W]       = rbuf_stat.level;  // bits 22:16
	end

	always_comb begin
		rdata = '0;
		if (csr_rd) begin
			case (addr)
				CSR_CMD:       rdata = cmd_q;
				CSR_STATUS:    rdata = status_w;
				CSR_DIAG0:     rdata = diag0_q;
				CSR_DIAG1:     rdata = diag1_q;
				CSR_BUF_CTRL:  rdata = '0;  // pulse bits only
				CSR_BUF_LEVEL: rdata = level_w;
				default:       rdata = '0;
			endcase
		end
	end

	// a soft reset always empties the buffer it targets
	a_wbuf_srst_empties: assert property (@(posedge m_avmm_clk) disable iff (!m_avmm_rst_n)
		wbuf_srst |=> (wbuf_stat.level == '0) && !wbuf_stat.overflow);

endmodule

/* hdl/spim_access_decode.sv */
// routes host and spi strobes to the buffers or registers and returns registered host read data
`timescale 1ns/10ps

module spim_access_decode
	import spim_pkg::*;
(
	input  logic              m_avmm_clk,
	input  logic              m_avmm_rst_n,
	input  logic              avbreg_read,
	input  logic              avbreg_write,
	input  logic [15:0]       avbreg_addr,
	input  logic              spi_read,
	input  logic              spi_write,
	input  logic [15:0]       spi_rd_addr,
	input  logic [15:0]       spi_wr_addr,
	input  logic [DATA_W-1:0] rbuf_head,
	input  logic [DATA_W-1:0] csr_rdata,
	output logic              wbuf_push,
	output logic              wbuf_pop,
	output logic              rbuf_push,
	output logic              rbuf_pop,
	output logic              csr_wr,
	output logic              csr_rd,
	output logic              avbreg_waitreq,
	output logic [DATA_W-1:0] avbreg_rdata,
	output logic              avbreg_rdatavld
);

	function automatic acc_kind_e classify(input logic [15:0] a);
		acc_kind_e k;
		if (a < WBUF_BASE)
			k = ACC_CSR;
		else if (a <= WBUF_LAST)
			k = ACC_WBUF;
		else if ((a >= RBUF_BASE) && (a <= RBUF_LAST))
			k = ACC_RBUF;
		else
			k = ACC_NONE;
		return k;
	endfunction

	acc_kind_e host_kind;
	logic      rd_acc;
	logic      wr_acc;

	assign host_kind = classify(avbreg_addr);

	// registers are locked out while the spi side is moving data
	assign avbreg_waitreq = (avbreg_read | avbreg_write) & (host_kind == ACC_CSR) &
	                        (spi_read | spi_write);

	assign rd_acc = avbreg_read & ~avbreg_waitreq;
	assign wr_acc = avbreg_write & ~avbreg_waitreq;

	assign wbuf_push = wr_acc & (host_kind == ACC_WBUF);
	assign rbuf_pop  = rd_acc & (host_kind == ACC_RBUF);
	assign csr_wr    = wr_acc & (host_kind == ACC_CSR);
	assign csr_rd    = rd_acc & (host_kind == ACC_CSR);
	assign wbuf_pop  = spi_read & (classify(spi_rd_addr) == ACC_WBUF);  // every cycle high
	assign rbuf_push = spi_write & (classify(spi_wr_addr) == ACC_RBUF);

	//////////////////////////////////////////////////
	// read return, one cycle after accept
	//////////////////////////////////////////////////
	always_ff @(posedge m_avmm_clk or negedge m_avmm_rst_n) begin
		if (!m_avmm_rst_n)
			avbreg_rdatavld <= 1'b0;
		else
			avbreg_rdatavld <= rd_acc;
	end

	always_ff @(posedge m_avmm_clk) begin
		if (rd_acc)
			avbreg_rdata <= (host_kind == ACC_RBUF) ? rbuf_head :
			                (host_kind == ACC_CSR)  ? csr_rdata : '0;
	end

	a_rdatavld_cause: assert property (@(posedge m_avmm_clk) disable iff (!m_avmm_rst_n)
		$rose(avbreg_rdatavld) |-> $past(rd_acc));

endmodule

/* hdl/spim_reg_top.sv */
// spi master register front end, joining both word buffers, the access decoder and the registers
`timescale 1ns/10ps

module spim_reg_top
	import spim_pkg::*;
(
	input  logic              m_avmm_clk,
	input  logic              m_avmm_rst_n,
	// host port
	input  logic              avbreg_read,
	input  logic              avbreg_write,
	input  logic [15:0]       avbreg_addr,
	input  logic [DATA_W-1:0] avbreg_wdata,
	output logic [DATA_W-1:0] avbreg_rdata,
	output logic              avbreg_rdatavld,
	output logic              avbreg_waitreq,
	// spi shifter side
	input  logic              spi_read,      // pop the write buffer
	input  logic              spi_write,     // push miso_data
	input  logic              cmd_is_read,
	input  logic [15:0]       spi_rd_addr,
	input  logic [15:0]       spi_wr_addr,
	input  logic [DATA_W-1:0] miso_data,
	output logic [DATA_W-1:0] mosi_data,
	input  logic              stransvld_up,
	input  logic              ssn_off_pulse,
	input  logic [DATA_W-1:0] dbg_bus0,
	input  logic [DATA_W-1:0] dbg_bus1,
	output spim_cmd_t         spim_cmd
);

	buf_stat_t         wbuf_stat;
	buf_stat_t         rbuf_stat;
	logic [DATA_W-1:0] wbuf_head;
	logic [DATA_W-1:0] rbuf_head;
	logic [DATA_W-1:0] csr_rdata;
	logic              wbuf_push, wbuf_pop, wbuf_srst;
	logic              rbuf_push, rbuf_pop, rbuf_srst;
	logic              csr_wr, csr_rd;

	// host to slave words
	spim_buf_fifo i_wbuf (
		.m_avmm_clk, .m_avmm_rst_n,
		.push(wbuf_push), .pop(wbuf_pop), .srst(wbuf_srst),
		.wrdata(avbreg_wdata), .head(wbuf_head), .stat(wbuf_stat)
	);

	// slave to host words
	spim_buf_fifo i_rbuf (
		.m_avmm_clk, .m_avmm_rst_n,
		.push(rbuf_push), .pop(rbuf_pop), .srst(rbuf_srst),
		.wrdata(miso_data), .head(rbuf_head), .stat(rbuf_stat)
	);

	spim_access_decode i_decode (
		.m_avmm_clk, .m_avmm_rst_n, .avbreg_read, .avbreg_write, .avbreg_addr,
		.spi_read, .spi_write, .spi_rd_addr, .spi_wr_addr, .rbuf_head, .csr_rdata,
		.wbuf_push, .wbuf_pop, .rbuf_push, .rbuf_pop, .csr_wr, .csr_rd,
		.avbreg_waitreq, .avbreg_rdata, .avbreg_rdatavld
	);

	spim_csr i_csr (
		.m_avmm_clk, .m_avmm_rst_n, .csr_wr, .csr_rd,
		.addr(csr_addr_e'(avbreg_addr)), .wdata(avbreg_wdata),
		.stransvld_up, .ssn_off_pulse, .dbg_bus0, .dbg_bus1, .wbuf_stat, .rbuf_stat,
		.rdata(csr_rdata), .wbuf_srst, .rbuf_srst, .spim_cmd
	);

	assign mosi_data = (spi_read & ~cmd_is_read) ? wbuf_head : '0;  // idle low between words

endmodule

/* sim/tb_spim_cases.svh */
// stimulus and expected value table for the spi master register testbench, included by it
`ifndef TB_SPIM_CASES_SVH
`define TB_SPIM_CASES_SVH

task automatic load_cases();
	// columns: op, repeat, address, data, check kind, expected, cmd_is_read
	add_step(OP_PULSE,  1, 16'h0000,      32'h0,         CHK_CMD,   32'h0);  // idle after reset
	add_step(OP_HWR,    1, CSR_CMD,       32'h8000_0029, CHK_CMD,   32'h8000_0029);
	add_step(OP_HRD,    1, CSR_CMD,       32'h0,         CHK_LIT,   32'h8000_0029);

	// write buffer drained onto mosi
	add_step(OP_HWR,    4, WBUF_BASE,     32'h0,         CHK_NONE,  32'h0);
	add_step(OP_SPIRD,  4, WBUF_BASE,     32'h0,         CHK_MODEL, 32'h0);
	add_step(OP_HWR,    2, WBUF_BASE,     32'h0,         CHK_NONE,  32'h0);
	add_step(OP_SPIRD,  1, WBUF_BASE,     32'h0,         CHK_MODEL, 32'h0, 1'b1);  // mosi low
	add_step(OP_SPIRD,  1, WBUF_BASE,     32'h0,         CHK_MODEL, 32'h0);

	// miso words returned to the host
	add_step(OP_SPIWR,  3, RBUF_BASE,     32'h0,         CHK_NONE,  32'h0);
	add_step(OP_HRD,    1, CSR_BUF_LEVEL, 32'h0,         CHK_LIT,   32'h0003_0000);
	add_step(OP_HRD,    3, RBUF_BASE,     32'h0,         CHK_MODEL, 32'h0);
	add_step(OP_HRD,    1, CSR_BUF_LEVEL, 32'h0,         CHK_LIT,   32'h0);

	// overflow, underflow and soft reset
	add_step(OP_HWR,   65, WBUF_BASE,     32'h0,         CHK_NONE,  32'h0);
	add_step(OP_HRD,    1, CSR_STATUS,    32'h0,         CHK_LIT,   32'h1);
	add_step(OP_HRD,    1, CSR_BUF_LEVEL, 32'h0,         CHK_LIT,   32'h40);
	add_step(OP_HRD,    1, RBUF_BASE,     32'h0,         CHK_MODEL, 32'h0);  // empty pop
	add_step(OP_HRD,    1, CSR_STATUS,    32'h0,         CHK_LIT,   32'h9);
	add_step(OP_HWR,    1, CSR_BUF_CTRL,  32'h3,         CHK_NONE,  32'h0);
	add_step(OP_HRD,    1, CSR_STATUS,    32'h0,         CHK_LIT,   32'h0);
	add_step(OP_HRD,    1, CSR_BUF_LEVEL, 32'h0,         CHK_LIT,   32'h0);

	// transaction valid clear and diag capture
	add_step(OP_PULSE,  1, 16'h0001,      32'h0,         CHK_CMD,   32'h8000_0028);
	add_step(OP_HRD,    1, CSR_CMD,       32'h0,         CHK_LIT,   32'h8000_0028);
	add_step(OP_HWR,    1, CSR_CMD,       32'h8000_0029, CHK_CMD,   32'h8000_0029);
	add_step(OP_PULSE,  1, 16'h0002,      32'hCAFE_0001, CHK_CMD,   32'h8000_0029);
	add_step(OP_HRD,    1, CSR_DIAG0,     32'h0,         CHK_LIT,   32'hCAFE_0001);
	add_step(OP_PULSE,  1, 16'h0003,      32'h1234_5678, CHK_CMD,   32'h8000_0028);
	add_step(OP_HRD,    1, CSR_DIAG0,     32'h0,         CHK_LIT,   32'hCAFE_0001);  // no load
	add_step(OP_HRD,    1, CSR_DIAG1,     32'h0,         CHK_LIT,   32'h5A5A_A5A5);

	// register write held off while spi_write is high
	add_step(OP_LOCKED_WR, 3, CSR_CMD,    32'h4000_0011, CHK_CMD,   32'h4000_0011);
	add_step(OP_HRD,    1, CSR_CMD,       32'h0,         CHK_LIT,   32'h4000_0011);
endtask

`endif

/* sim/tb_spim_reg_top.sv */
// testbench for the spi master register front end, compiled through flist.f and run by run_sim.sh
`timescale 1ns/10ps

module tb_spim_reg_top
	import spim_pkg::*;
();

	typedef enum logic [2:0] {OP_HWR, OP_HRD, OP_SPIRD, OP_SPIWR, OP_PULSE, OP_LOCKED_WR} op_e;
	typedef enum logic [1:0] {CHK_NONE, CHK_LIT, CHK_MODEL, CHK_CMD} chk_e;

	typedef struct packed {
		op_e         op;
		int          rep;   // accesses, or strobe cycles on the spi side
		logic [15:0] addr;  // pulse steps: bit 0 stransvld_up, bit 1 ssn_off_pulse
		logic [31:0] data;
		chk_e        chk;
		logic [31:0] exp;
		logic        aux;   // cmd_is_read during spi reads
	} step_t;

	logic              m_avmm_clk = 1'b0;
	logic              m_avmm_rst_n;
	logic              avbreg_read, avbreg_write, avbreg_rdatavld, avbreg_waitreq;
	logic [15:0]       avbreg_addr;
	logic [DATA_W-1:0] avbreg_wdata, avbreg_rdata;
	logic              spi_read, spi_write, cmd_is_read, stransvld_up, ssn_off_pulse;
	logic [15:0]       spi_rd_addr, spi_wr_addr;
	logic [DATA_W-1:0] miso_data, mosi_data, dbg_bus0, dbg_bus1;
	spim_cmd_t         spim_cmd;

	step_t             cases[$];
	logic [DATA_W-1:0] wmodel[$];   // expected write buffer contents
	logic [DATA_W-1:0] rmodel[$];
	integer            seed = 92628;
	int                errors = 0;

	spim_reg_top uut (.*);

	always #5 m_avmm_clk = ~m_avmm_clk;

	task automatic add_step(input op_e op, input int rep, input logic [15:0] addr,
	                        input logic [31:0] data, input chk_e chk, input logic [31:0] exp,
	                        input logic aux = 1'b0);
		cases.push_back(step_t'{op, rep, addr, data, chk, exp, aux});
	endtask

	`include "tb_spim_cases.svh"

	task automatic check_word(input string name, input logic [DATA_W-1:0] got,
	                          input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_cmd(input spim_cmd_t got, input spim_cmd_t exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t spim_cmd got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic push_word(ref logic [DATA_W-1:0] q[$], input logic [DATA_W-1:0] w);
		if (q.size() < BUF_DEPTH)
			q.push_back(w);  // full buffer drops it
	endtask

	task automatic pop_word(ref logic [DATA_W-1:0] q[$], output logic [DATA_W-1:0] w);
		w = (q.size() > 0) ? q.pop_front() : '0;  // empty pop reads zero
	endtask

	//////////////////////////////////////////////////
	// one host access, held while waitreq is high
	//////////////////////////////////////////////////
	task automatic host_access(input logic wr, input logic [15:0] addr,
	                           input logic [DATA_W-1:0] wdata,
	                           output logic [DATA_W-1:0] rdata, output int waits);
		waits = 0;
		rdata = '0;
		@(posedge m_avmm_clk);
		avbreg_read  <= ~wr;
		avbreg_write <= wr;
		avbreg_addr  <= addr;
		avbreg_wdata <= wdata;
		@(negedge m_avmm_clk);
		while (avbreg_waitreq) begin
			waits++;
			@(negedge m_avmm_clk);
		end
		@(posedge m_avmm_clk);  // accepted on this edge
		avbreg_read  <= 1'b0;
		avbreg_write <= 1'b0;
		@(negedge m_avmm_clk);
		if (!wr) begin
			if (!avbreg_rdatavld) begin
				errors++;
				$display("%0t read of %h accepted, but no avbreg_rdatavld followed", $time, addr);
			end
			rdata = avbreg_rdata;
		end
	endtask

	initial begin
		step_t             s;
		logic [DATA_W-1:0] word;
		logic [DATA_W-1:0] rd;
		int                waits;
		m_avmm_rst_n  = 1'b0;
		avbreg_read   = 1'b0;
		avbreg_write  = 1'b0;
		avbreg_addr   = '0;
		avbreg_wdata  = '0;
		spi_read      = 1'b0;
		spi_write     = 1'b0;
		cmd_is_read   = 1'b0;
		spi_rd_addr   = '0;
		spi_wr_addr   = '0;
		miso_data     = '0;
		stransvld_up  = 1'b0;
		ssn_off_pulse = 1'b0;
		dbg_bus0      = '0;
		dbg_bus1      = 32'h5A5A_A5A5;  // held, so diag1 reads back known
		load_cases();
		repeat (2) @(posedge m_avmm_clk);
		m_avmm_rst_n <= 1'b1;

		foreach (cases[i]) begin
			s = cases[i];
			case (s.op)
				OP_HWR: repeat (s.rep) begin
					word = s.data;
					if (s.addr >= WBUF_BASE && s.addr <= WBUF_LAST) begin
						word = $random(seed);
						push_word(wmodel, word);
					end
					host_access(1'b1, s.addr, word, rd, waits);
					if (s.addr == CSR_BUF_CTRL && s.data[CTRL_WBUF_SRST])
						wmodel.delete();
					if (s.addr == CSR_BUF_CTRL && s.data[CTRL_RBUF_SRST])
						rmodel.delete();
					if (s.chk == CHK_CMD)
						check_cmd(spim_cmd, spim_cmd_t'(s.exp));
				end
				OP_HRD: repeat (s.rep) begin
					host_access(1'b0, s.addr, '0, rd, waits);
					word = s.exp;
					if (s.chk == CHK_MODEL)
						pop_word(rmodel, word);
					if (s.chk != CHK_NONE)
						check_word("avbreg_rdata", rd, word);
				end
				OP_SPIRD: begin
					@(posedge m_avmm_clk);
					spi_read    <= 1'b1;
					spi_rd_addr <= WBUF_BASE;
					cmd_is_read <= s.aux;
					repeat (s.rep) begin
						@(negedge m_avmm_clk);
						pop_word(wmodel, word);
						check_word("mosi_data", mosi_data, s.aux ? '0 : word);
						@(posedge m_avmm_clk);  // word leaves the buffer here
					end
					spi_read    <= 1'b0;
					cmd_is_read <= 1'b0;
				end
				OP_SPIWR: begin
					repeat (s.rep) begin
						@(posedge m_avmm_clk);
						word = $random(seed);
						spi_write   <= 1'b1;
						spi_wr_addr <= RBUF_BASE;
						miso_data   <= word;
						push_word(rmodel, word);
					end
					@(posedge m_avmm_clk);
					spi_write <= 1'b0;
				end
				OP_PULSE: begin
					@(posedge m_avmm_clk);
					stransvld_up  <= s.addr[0];
					ssn_off_pulse <= s.addr[1];
					dbg_bus0      <= s.data;
					@(posedge m_avmm_clk);
					stransvld_up  <= 1'b0;
					ssn_off_pulse <= 1'b0;
					@(negedge m_avmm_clk);
					if (s.chk == CHK_CMD)
						check_cmd(spim_cmd, spim_cmd_t'(s.exp));
				end
				OP_LOCKED_WR: begin
					@(posedge m_avmm_clk);
					spi_write   <= 1'b1;
					spi_wr_addr <= 16'h0000;  // outside the read buffer, nothing pushed
					fork
						host_access(1'b1, s.addr, s.data, rd, waits);
						begin
							repeat (s.rep) @(posedge m_avmm_clk);
							spi_write <= 1'b0;
							@(negedge m_avmm_clk);
							// last edge with spi_write high is behind us
							if (s.chk == CHK_CMD && spim_cmd === spim_cmd_t'(s.exp)) begin
								errors++;
								$display("%0t register write landed while spi_write was high",
								         $time);
							end
						end
					join
					if (waits == 0) begin
						errors++;
						$display("%0t register write during spi_write was never held off", $time);
					end
					if (s.chk == CHK_CMD)
						check_cmd(spim_cmd, spim_cmd_t'(s.exp));
				end
				default: ;
			endcase
		end

		repeat (2) @(posedge m_avmm_clk);
		$display("steps %0d, errors %0d", cases.size(), errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// watchdog, 20 clock periods per table repetition
	initial begin
		int budget;
		budget = 0;
		#1;
		foreach (cases[i])
			budget += cases[i].rep;
		#(budget * 20 * 10 + 100);
		$display("timeout: run did not finish within %0d cycles", budget * 20);
		$display(">>> FAIL");
		$finish;
	end

endmodule

/* flist.f */
+incdir+sim
hdl/spim_pkg.sv
hdl/spim_buf_fifo.sv
hdl/spim_csr.sv
hdl/spim_access_decode.sv
hdl/spim_reg_top.sv
sim/tb_spim_reg_top.sv

/* run_sim.sh */
#!/bin/sh
# build the register front end and its testbench with verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_spim_reg_top -f flist.f -o sim_bin
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_bin > "$LOG" 2>&1
STATUS=$?
cat "$LOG"
if [ $STATUS -ne 0 ]; then
	echo "simulation exited with status $STATUS"
	exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
	exit 0
fi
exit 1
